//--- include/sym_fir_consts.svh
`ifndef SYM_FIR_CONSTS_SVH
`define SYM_FIR_CONSTS_SVH

// systolic taps, the impulse response is twice as long.
`define FIR_NBTAP 8

`define FIR_DSIZE 16 // input sample width.
`define FIR_CSIZE 18 // coefficient width.

// product and cascade width.
`define FIR_PSIZE 34

`define FIR_OSIZE 16 // output sample width.

// right shift ahead of rounding to the output width.
`define FIR_SHIFT 17

// in_valid to fir_out.valid, taps plus pipeline and output register.
`define FIR_LATENCY (`FIR_NBTAP + 5)

`endif

//--- design/fir_data_pkg.sv
`include "sym_fir_consts.svh"

package fir_data_pkg;

    // input samples as they enter the array.
    typedef logic signed [`FIR_DSIZE-1:0] sample_t;

    typedef logic signed [`FIR_CSIZE-1:0] coeff_t;

    // forward plus mirrored sample, one bit wider.
    typedef logic signed [`FIR_DSIZE:0] preadd_t;

    // products and the cascade share this width.
    typedef logic signed [`FIR_PSIZE-1:0] acc_t;

    typedef logic signed [`FIR_OSIZE-1:0] out_sample_t;

    // filter result as seen at the top.
    typedef struct packed {
        logic        valid; // one cycle strobe.
        logic        sat;   // result was clipped.
        out_sample_t data;
    } fir_out_t;

endpackage

//--- design/fir_ctrl_pkg.sv
`include "sym_fir_consts.svh"

package fir_ctrl_pkg;

    // addresses one systolic tap.
    typedef logic [$clog2(`FIR_NBTAP)-1:0] tap_idx_t;

    // single cycle coefficient write.
    typedef struct packed {
        logic                 strobe;
        tap_idx_t             addr;
        fir_data_pkg::coeff_t value;
    } coeff_wr_t;

endpackage

//--- design/fir_sample_delay.sv
`timescale 1ns/1ps
`include "sym_fir_consts.svh"

module fir_sample_delay (
    input  logic                  clk,
    input  logic                  rst,
    input  fir_data_pkg::sample_t din,
    output fir_data_pkg::sample_t dout
);
    import fir_data_pkg::*;

    localparam int DEPTH = 2 * `FIR_NBTAP;

    sample_t stage_q [DEPTH];

    // mirrored sample for every tap, one shared line.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign dout = stage_q[DEPTH-1]; // 2*nbtap cycles after din.

endmodule

//--- design/fir_symmetric_tap.sv
`timescale 1ns/1ps

module fir_symmetric_tap (
    input  logic                  clk,
    input  logic                  rst,
    input  fir_data_pkg::coeff_t  coeff,
    input  fir_data_pkg::sample_t fwd_in,
    input  fir_data_pkg::sample_t mirror_in,
    input  fir_data_pkg::acc_t    casc_in,
    output fir_data_pkg::sample_t fwd_out,
    output fir_data_pkg::acc_t    casc_out
);
    import fir_data_pkg::*;

    localparam int ACC_MSB = $bits(acc_t) - 1;

    coeff_t  coeff_q;
    sample_t fwd_q1;
    sample_t fwd_q2;
    sample_t mirror_q;
    preadd_t preadd;
    acc_t    product;

    always_ff @(posedge clk) begin
        if (rst) begin
            coeff_q  <= '0;
            fwd_q1   <= '0;
            fwd_q2   <= '0;
            mirror_q <= '0;
            preadd   <= '0;
            product  <= '0;
            casc_out <= '0;
        end else begin
            coeff_q  <= coeff;
            fwd_q1   <= fwd_in;
            fwd_q2   <= fwd_q1;   // two stages per tap on the forward path.
            mirror_q <= mirror_in;
            // symmetric pair folded before the multiply.
            preadd   <= preadd_t'(fwd_q2) + preadd_t'(mirror_q);
            product  <= acc_t'(preadd) * acc_t'(coeff_q);
            casc_out <= product + casc_in;
        end
    end

    assign fwd_out = fwd_q2;

    // same-sign operands must keep their sign in the cascade sum.
    cascade_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        ($past(product[ACC_MSB]) == $past(casc_in[ACC_MSB]))
            |-> (casc_out[ACC_MSB] == $past(product[ACC_MSB]))
    ) else $error("cascade sum overflow");

endmodule

//--- design/fir_coeff_bank.sv
`timescale 1ns/1ps
`include "sym_fir_consts.svh"

module fir_coeff_bank (
    input  logic                   clk,
    input  logic                   rst,
    input  fir_ctrl_pkg::coeff_wr_t coeff_wr,
    output fir_data_pkg::coeff_t   coeffs [`FIR_NBTAP]
);
    import fir_data_pkg::*;
    import fir_ctrl_pkg::*;

    // one register per systolic tap.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `FIR_NBTAP; i++) begin
                coeffs[i] <= '0;
            end
        end else if (coeff_wr.strobe) begin
            coeffs[coeff_wr.addr] <= coeff_wr.value; // visible next cycle.
        end
    end

    // a write must carry a known tap address.
    coeff_addr_valid: assert property (
        @(posedge clk) disable iff (rst)
        coeff_wr.strobe |-> !$isunknown(coeff_wr.addr)
    ) else $error("coefficient write to bad address %0d", coeff_wr.addr);

endmodule

//--- design/fir_output_stage.sv
`timescale 1ns/1ps
`include "sym_fir_consts.svh"

module fir_output_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  fir_data_pkg::acc_t     acc,
    output fir_data_pkg::fir_out_t fir_out
);
    import fir_data_pkg::*;

    localparam int VLEN  = `FIR_LATENCY - 1; // output register adds the last cycle.
    localparam int RSIZE = `FIR_PSIZE + 1;   // headroom for the rounding add.
    localparam int SSIZE = RSIZE - `FIR_SHIFT;

    localparam logic [RSIZE-1:0] HALF_LSB = RSIZE'(1) << (`FIR_SHIFT - 1);
    localparam out_sample_t OUT_MAX = {1'b0, {(`FIR_OSIZE-1){1'b1}}};
    localparam out_sample_t OUT_MIN = {1'b1, {(`FIR_OSIZE-1){1'b0}}};

    logic [VLEN-1:0]  valid_line;
    logic [RSIZE-1:0] rounded;
    logic [SSIZE-1:0] shifted;
    logic             pos_clip;
    logic             neg_clip;
    out_sample_t      clipped;

    assign rounded = {acc[`FIR_PSIZE-1], acc} + HALF_LSB;
    assign shifted = rounded[RSIZE-1:`FIR_SHIFT]; // arithmetic shift.

    // upper bits must all match the sign to fit the output width.
    assign pos_clip = !shifted[SSIZE-1] && (|shifted[SSIZE-2:`FIR_OSIZE-1]);
    assign neg_clip = shifted[SSIZE-1] && !(&shifted[SSIZE-2:`FIR_OSIZE-1]);

    always_comb begin
        if (pos_clip) begin
            clipped = OUT_MAX;
        end else if (neg_clip) begin
            clipped = OUT_MIN;
        end else begin
            clipped = out_sample_t'(shifted[`FIR_OSIZE-1:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_line <= '0;
            fir_out    <= '0;
        end else begin
            valid_line    <= {valid_line[VLEN-2:0], in_valid};
            fir_out.valid <= valid_line[VLEN-1];
            fir_out.sat   <= valid_line[VLEN-1] & (pos_clip | neg_clip); // only on real samples.
            fir_out.data  <= clipped;
        end
    end

    // nothing can emerge before a full pass through the pipeline.
    quiet_after_reset: assert property (
        @(posedge clk) disable iff (rst)
        $fell(rst) |-> (!fir_out.valid && !fir_out.sat) [*`FIR_LATENCY]
    ) else $error("output strobe too soon after reset");

    sat_at_limit: assert property (
        @(posedge clk) disable iff (rst)
        fir_out.sat |-> (fir_out.valid && (fir_out.data == OUT_MAX || fir_out.data == OUT_MIN))
    ) else $error("sat set on unclipped data %0d", fir_out.data);

endmodule

//--- design/sym_fir_top.sv
`timescale 1ns/1ps
`include "sym_fir_consts.svh"

module sym_fir_top (
    input  logic                    clk,
    input  logic                    rst,
    input  fir_ctrl_pkg::coeff_wr_t coeff_wr,
    input  logic                    in_valid,
    input  fir_data_pkg::sample_t   in_data,
    output fir_data_pkg::fir_out_t  fir_out
);
    import fir_data_pkg::*;
    import fir_ctrl_pkg::*;

    coeff_t  coeffs [`FIR_NBTAP];
    sample_t mirror;

    // element i is the input of tap i.
    sample_t fwd_chain  [`FIR_NBTAP+1];
    acc_t    casc_chain [`FIR_NBTAP+1];

    assign fwd_chain[0]  = in_data;
    assign casc_chain[0] = '0; // head of the cascade.

    fir_coeff_bank u_coeff_bank (
        .clk      (clk),
        .rst      (rst),
        .coeff_wr (coeff_wr),
        .coeffs   (coeffs)
    );

    fir_sample_delay u_sample_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (in_data),
        .dout (mirror)
    );

    // forward data moves two cycles per tap, the cascade one.
    for (genvar i = 0; i < `FIR_NBTAP; i++) begin : g_tap
        fir_symmetric_tap u_tap (
            .clk       (clk),
            .rst       (rst),
            .coeff     (coeffs[i]),
            .fwd_in    (fwd_chain[i]),
            .mirror_in (mirror),
            .casc_in   (casc_chain[i]),
            .fwd_out   (fwd_chain[i+1]),
            .casc_out  (casc_chain[i+1])
        );
    end

    // last cascade output is the full filter sum.
    fir_output_stage u_output_stage (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .acc      (casc_chain[`FIR_NBTAP]),
        .fir_out  (fir_out)
    );

endmodule

//--- testbench/sym_fir_ref.svh
`ifndef SYM_FIR_REF_SVH
`define SYM_FIR_REF_SVH

// expected fir_out for one output strobe.
// hist[0] is the newest sample of the window, hist[15] the oldest.
function automatic fir_out_t model_output(
    input sample_t hist [2*`FIR_NBTAP],
    input coeff_t  coef [`FIR_NBTAP]
);
    longint   sum;
    longint   scaled;
    longint   hi;
    longint   lo;
    int       h_idx;
    fir_out_t res;

    sum = 0;
    hi  = (longint'(1) << (`FIR_OSIZE - 1)) - 1;
    lo  = -(longint'(1) << (`FIR_OSIZE - 1));

    for (int j = 0; j < 2 * `FIR_NBTAP; j++) begin
        // response runs h0..h7, then back down h7..h0.
        h_idx = (j < `FIR_NBTAP) ? j : 2 * `FIR_NBTAP - 1 - j;
        sum += longint'(hist[j]) * longint'(coef[h_idx]);
    end

    // half lsb, then arithmetic shift.
    scaled = (sum + (longint'(1) << (`FIR_SHIFT - 1))) >>> `FIR_SHIFT;

    res.valid = 1'b1;
    if (scaled > hi) begin
        res.sat  = 1'b1;
        res.data = out_sample_t'(hi);
    end else if (scaled < lo) begin
        res.sat  = 1'b1;
        res.data = out_sample_t'(lo);
    end else begin
        res.sat  = 1'b0;
        res.data = out_sample_t'(scaled); // fits, low bits are the value.
    end
    return res;
endfunction

`endif

//--- testbench/sym_fir_tb.sv
`timescale 1ns/1ps
`include "sym_fir_consts.svh"

module sym_fir_tb;
    import fir_data_pkg::*;
    import fir_ctrl_pkg::*;

    localparam int      NTAPS   = 2 * `FIR_NBTAP; // full response length.
    localparam int      LAT     = `FIR_LATENCY;
    localparam sample_t IMPULSE = 16'sd16384;

    logic      clk;
    logic      rst;
    coeff_wr_t coeff_wr;
    logic      in_valid;
    sample_t   in_data;
    fir_out_t  fir_out;

    `include "sym_fir_ref.svh"

    logic [31:0] lcg_state;
    coeff_t      coef_copy [`FIR_NBTAP]; // what was written to the bank.
    sample_t     x_hist [$];             // sample taken by the DUT at each edge.
    logic        v_hist [$];
    sample_t     out_log [$];            // data of every output strobe.

    int out_count;
    int pos_sat_count;
    int neg_sat_count;
    int plain_count;
    int mon_errors;
    int test_errors;
    int in_count;
    int tests_run;
    int tests_failed;

    sym_fir_top DUT (
        .clk      (clk),
        .rst      (rst),
        .coeff_wr (coeff_wr),
        .in_valid (in_valid),
        .in_data  (in_data),
        .fir_out  (fir_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // checks every output against the model, 13 edges after the input.
    always @(posedge clk) begin : monitor
        sample_t  window [NTAPS];
        fir_out_t expected;
        int       cyc;
        int       idx;

        x_hist.push_back(rst ? '0 : in_data); // reset clears the whole pipeline.
        v_hist.push_back(rst ? 1'b0 : in_valid);
        cyc = x_hist.size() - 1;
        expected = '0;
        if (cyc >= LAT && v_hist[cyc - LAT]) begin
            for (int j = 0; j < NTAPS; j++) begin
                idx = cyc - LAT - j;
                window[j] = (idx >= 0) ? x_hist[idx] : '0;
            end
            expected = model_output(window, coef_copy);
        end
        if (rst) begin
            out_count     <= 0;
            pos_sat_count <= 0;
            neg_sat_count <= 0;
            plain_count   <= 0;
            mon_errors    <= 0;
        end else begin
            assert (fir_out.valid == expected.valid) else begin
                $display("FAILED %0t: fir_out.valid is %0b, expected %0b",
                         $time, fir_out.valid, expected.valid);
                mon_errors <= mon_errors + 1;
            end
            if (fir_out.valid && expected.valid) begin
                assert (fir_out == expected) else begin
                    $display("FAILED %0t: data %0d sat %0b, expected data %0d sat %0b",
                             $time, fir_out.data, fir_out.sat, expected.data, expected.sat);
                    mon_errors <= mon_errors + 1;
                end
            end
            if (fir_out.valid) begin
                out_count <= out_count + 1;
                out_log.push_back(fir_out.data);
                if (fir_out.sat && !fir_out.data[`FIR_OSIZE-1]) begin
                    pos_sat_count <= pos_sat_count + 1;
                end else if (fir_out.sat) begin
                    neg_sat_count <= neg_sat_count + 1;
                end else begin
                    plain_count <= plain_count + 1;
                end
            end
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int error_total();
        return mon_errors + test_errors;
    endfunction

    task automatic drive_sample(input logic valid, input sample_t data);
        @(posedge clk);
        in_valid <= valid;
        in_data  <= data;
        if (valid) begin
            in_count++;
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            drive_sample(1'b0, '0);
        end
    endtask

    task automatic write_coeff(input tap_idx_t tap, input coeff_t c);
        @(posedge clk);
        coeff_wr <= '{strobe: 1'b1, addr: tap, value: c};
        coef_copy[tap] = c;
    endtask

    // loads all taps, then flushes the array with zeros.
    task automatic load_coeffs(input coeff_t c [`FIR_NBTAP]);
        for (int i = 0; i < `FIR_NBTAP; i++) begin
            write_coeff(tap_idx_t'(i), c[i]);
        end
        @(posedge clk);
        coeff_wr <= '0;
        idle_cycles(2 * NTAPS);
    endtask

    task automatic wait_drain(input string what);
        for (int i = 0; i < 4 * LAT && out_count < in_count; i++) begin
            drive_sample(1'b0, '0);
        end
        if (out_count < in_count) begin
            $display("%s: only %0d of %0d output strobes arrived before the timeout",
                     what, out_count, in_count);
            test_errors++;
        end else begin
            idle_cycles(4); // no extra strobes may follow.
            assert (out_count == in_count) else begin
                $display("FAILED %0t: %s gave %0d output strobes for %0d inputs",
                         $time, what, out_count, in_count);
                test_errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        tests_run++;
        if (error_total() == errs_at_start) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin : stimulus
        coeff_t      h [`FIR_NBTAP];
        logic [31:0] r;
        int          errs;
        int          seen;
        int          start;
        int          tap;
        int          burst_left;
        logic        burst_on;
        longint      want;
        int          pos0;
        int          neg0;
        int          plain0;

        rst       <= 1'b1;
        coeff_wr  <= '0;
        in_valid  <= 1'b0;
        in_data   <= '0;
        lcg_state = 32'h9141_d429;
        test_errors  = 0;
        in_count     = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < `FIR_NBTAP; i++) begin
            coef_copy[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // reset: quiet until one strobe comes through.
        errs = error_total();
        for (int i = 0; i < 20; i++) begin
            drive_sample(1'b0, '0);
            assert (!fir_out.valid && !fir_out.sat) else begin
                $display("FAILED %0t: output strobe while idle after reset", $time);
                test_errors++;
            end
        end
        drive_sample(1'b1, '0);
        seen = 0;
        for (int i = 1; i <= 4 * LAT; i++) begin
            drive_sample(1'b0, '0);
            if (fir_out.valid) begin
                seen = i - 1; // edge that raised the strobe.
                break;
            end
        end
        if (seen == 0) begin
            $display("reset: no output strobe within %0d cycles", 4 * LAT);
            test_errors++;
        end else begin
            assert (seen == LAT) else begin
                $display("FAILED %0t: first strobe after %0d cycles, expected %0d",
                         $time, seen, LAT);
                test_errors++;
            end
        end
        wait_drain("reset");
        report_test("reset", errs);

        // impulse through distinct coefficients.
        errs = error_total();
        h = '{18'sd800, -18'sd2400, 18'sd4000, 18'sd12000,
              -18'sd16000, 18'sd40000, 18'sd96000, 18'sd131064};
        load_coeffs(h);
        start = out_log.size();
        drive_sample(1'b1, IMPULSE);
        for (int i = 1; i < NTAPS; i++) begin
            drive_sample(1'b1, '0);
        end
        wait_drain("impulse");
        if (out_log.size() < start + NTAPS) begin
            $display("impulse: response shorter than %0d samples", NTAPS);
            test_errors++;
        end else begin
            for (int i = 0; i < NTAPS; i++) begin
                tap  = (i < `FIR_NBTAP) ? i : NTAPS - 1 - i;
                want = longint'(IMPULSE) * longint'(h[tap]);
                want = (want + (longint'(1) << (`FIR_SHIFT - 1))) >>> `FIR_SHIFT;
                assert (longint'(out_log[start + i]) == want) else begin
                    $display("FAILED %0t: impulse sample %0d is %0d, expected %0d",
                             $time, i, out_log[start + i], want);
                    test_errors++;
                end
            end
        end
        report_test("impulse", errs);

        // random stream, every cycle valid.
        errs = error_total();
        for (int i = 0; i < `FIR_NBTAP; i++) begin
            r = next_random();
            h[i] = coeff_t'($signed(r[27:16])); // small enough not to clip.
        end
        load_coeffs(h);
        for (int i = 0; i < 200; i++) begin
            r = next_random();
            drive_sample(1'b1, sample_t'(r[31:16]));
        end
        wait_drain("random stream");
        report_test("random stream", errs);

        // sparse and bursty valid, data keeps moving in the gaps.
        errs = error_total();
        for (int i = 0; i < 160; i++) begin
            r = next_random();
            drive_sample(r[31:30] == 2'b00, sample_t'(r[23:8]));
        end
        burst_on   = 1'b1;
        burst_left = 0;
        for (int i = 0; i < 160; i++) begin
            r = next_random();
            if (burst_left == 0) begin
                burst_on   = ~burst_on;
                burst_left = int'(r[30:28]) + 1;
            end
            burst_left--;
            drive_sample(burst_on, sample_t'(r[31:16]));
        end
        wait_drain("valid gaps");
        report_test("valid gaps", errs);

        // full scale both ways, then small samples.
        errs   = error_total();
        pos0   = pos_sat_count;
        neg0   = neg_sat_count;
        plain0 = plain_count;
        for (int i = 0; i < `FIR_NBTAP; i++) begin
            h[i] = 18'sd12000;
        end
        load_coeffs(h);
        for (int i = 0; i < 24; i++) begin
            drive_sample(1'b1, 16'sd32767);
        end
        for (int i = 0; i < 24; i++) begin
            drive_sample(1'b1, -16'sd32768);
        end
        for (int i = 0; i < 24; i++) begin
            r = next_random();
            drive_sample(1'b1, sample_t'($signed(r[31:24])));
        end
        wait_drain("saturation");
        assert (pos_sat_count > pos0 && neg_sat_count > neg0 && plain_count > plain0)
        else begin
            $display("FAILED %0t: clipped +%0d -%0d, unclipped %0d",
                     $time, pos_sat_count - pos0, neg_sat_count - neg0, plain_count - plain0);
            test_errors++;
        end
        report_test("saturation", errs);

        $display("tests %0d, failed %0d, input strobes %0d, output strobes %0d, errors %0d",
                 tests_run, tests_failed, in_count, out_count, error_total());
        if (error_total() == 0 && tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- sym_fir.f
+incdir+include
+incdir+testbench
design/fir_data_pkg.sv
design/fir_ctrl_pkg.sv
design/fir_sample_delay.sv
design/fir_symmetric_tap.sv
design/fir_coeff_bank.sv
design/fir_output_stage.sv
design/sym_fir_top.sv
testbench/sym_fir_tb.sv

//--- run_sym_fir.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module sym_fir_tb -f sym_fir.f -o sym_fir_sim \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/sym_fir_sim 2>&1)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Test OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
